// File: fv_pkg.sv
// shared widths and types; LINE_W must equal FEAT_W * FV_PER_LINE and FV_PER_LINE a power of two
`default_nettype none

package fv_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int FEAT_W      = 16;
    localparam int FV_PER_LINE = 4;
    localparam int LINE_W      = FEAT_W * FV_PER_LINE;
    localparam int ADDR_W      = 8;
    localparam int TAG_W       = 2;
    localparam int MAX_FV      = 16;
    localparam int CNT_W       = $clog2(MAX_FV + 1);

    // features to lines is a right shift
    localparam int LINE_SHIFT  = $clog2(FV_PER_LINE);

    // --------------------
    // scalar types
    // --------------------
    typedef logic [LINE_W-1:0] fv_line_t;
    typedef logic [ADDR_W-1:0] fv_addr_t;
    typedef logic [TAG_W-1:0]  pe_tag_t;
    typedef logic [CNT_W-1:0]  fv_count_t;

    // --------------------
    // bundles
    // --------------------

    // sram port, enables active low
    typedef struct packed {
        logic     cen;
        logic     wen;
        fv_addr_t a;
        fv_line_t d;
    } sram_req_t;

    // registered write beat from the loader
    typedef struct packed {
        logic     sos;
        logic     eos;
        fv_addr_t a;
        fv_line_t data;
    } fv_write_t;

    // head of the read request queue
    typedef struct packed {
        logic     valid;
        fv_addr_t addr;
        pe_tag_t  tag;
    } rd_req_t;

    // one beat towards the edge processing elements
    typedef struct packed {
        logic     valid;
        logic     sos;
        logic     eos;
        pe_tag_t  tag;
        fv_line_t data;
    } pe_beat_t;

    // bank controller states
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        STREAM   = 2'd1,
        WRITE_FV = 2'd2
    } bank_state_t;

endpackage

`default_nettype wire

// File: fv_sram.sv
// behavioral single-port bank; one-cycle read, no reset, contents are undefined until written
`timescale 1ns/1ns
`default_nettype none

module fv_sram import fv_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic      clk,
    input  sram_req_t req,
    output fv_line_t  rdata
);

    fv_line_t mem [DEPTH];

    // write when both enables are low
    always_ff @(posedge clk) begin
        if (!req.cen && !req.wen) begin
            mem[req.a] <= req.d;
        end
    end

    // read data shows up one cycle after the request
    always_ff @(posedge clk) begin
        if (!req.cen && req.wen) begin
            rdata <= mem[req.a];
        end
    end

    // --------------------
    // checks
    // --------------------

    // the controller must never address past the end of the bank
    a_addr_range: assert property (
        @(posedge clk) !req.cen |-> (int'(req.a) < DEPTH)
    );

endmodule

`default_nettype wire

// File: fv_write_loader.sv
// host write stream to bank beats; wr_base is taken on the first beat, bursts are never split
`timescale 1ns/1ns
`default_nettype none

module fv_write_loader import fv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      wr_valid,
    input  logic      wr_last,
    input  fv_addr_t  wr_base,
    input  fv_line_t  wr_data,
    output logic      wr_ready,
    input  logic      bank_free,
    output fv_write_t wr_beat
);

    logic     open_q;
    fv_addr_t addr_q;
    fv_addr_t beat_addr;
    logic     xfer;

    // an open burst runs to its last beat regardless of the bank
    assign wr_ready  = open_q || bank_free;
    assign xfer      = wr_valid && wr_ready;
    assign beat_addr = open_q ? addr_q : wr_base;

    always_ff @(posedge clk) begin
        if (reset) begin
            open_q <= 1'b0;
        end else if (xfer) begin
            open_q <= !wr_last;
        end
    end

    // running address for the rest of the burst
    always_ff @(posedge clk) begin
        if (xfer) begin
            addr_q <= beat_addr + fv_addr_t'(1);
        end
    end

    // --------------------
    // beat register
    // --------------------

    // without a new beat the flags drop but address and data hold,
    // so a gap inside a burst only rewrites the last line with itself
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_beat.sos <= 1'b0;
            wr_beat.eos <= 1'b0;
        end else if (xfer) begin
            wr_beat <= '{sos: !open_q, eos: wr_last, a: beat_addr, data: wr_data};
        end else begin
            wr_beat.sos <= 1'b0;
            wr_beat.eos <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: fv_read_queue.sv
// small circular FIFO of read requests; a push and a pop may share a cycle, no bypass when empty
`timescale 1ns/1ns
`default_nettype none

module fv_read_queue import fv_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     req_valid,
    input  fv_addr_t req_addr,
    input  pe_tag_t  req_tag,
    output logic     req_ready,
    output rd_req_t  head,
    input  logic     rd_accept
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

    fv_addr_t addr_mem [QUEUE_DEPTH];
    pe_tag_t  tag_mem  [QUEUE_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign req_ready = (count != QCNT_W'(QUEUE_DEPTH));
    assign push      = req_valid && req_ready;
    assign pop       = rd_accept;

    assign head.valid = (count != '0);
    assign head.addr  = addr_mem[rd_ptr];
    assign head.tag   = tag_mem[rd_ptr];

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + QCNT_W'(1);
                2'b01:   count <= count - QCNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= req_addr;
            tag_mem[wr_ptr]  <= req_tag;
        end
    end

    // --------------------
    // checks
    // --------------------

    // controller only takes the head when one is there
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset) rd_accept |-> (count != '0)
    );

    // occupancy never runs past the storage
    a_no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        (count == QCNT_W'(QUEUE_DEPTH)) && !rd_accept |=> (count == QCNT_W'(QUEUE_DEPTH))
    );

endmodule

`default_nettype wire

// File: fv_bank_ctrl.sv
// bank scheduler; num_fv must be 1..MAX_FV and held during a read, PE side never stalls
`timescale 1ns/1ns
`default_nettype none

module fv_bank_ctrl import fv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  fv_count_t num_fv,
    input  fv_write_t wr_beat,
    input  rd_req_t   head,
    input  fv_line_t  sram_rdata,
    output logic      rd_accept,
    output logic      bank_free,
    output sram_req_t sram,
    output pe_beat_t  pe_out,
    output logic      busy
);

    bank_state_t state;
    bank_state_t nx_state;
    fv_count_t   cnt;
    fv_count_t   nx_cnt;
    fv_count_t   num_lines;
    fv_addr_t    rd_addr;
    fv_addr_t    nx_rd_addr;
    pe_tag_t     tag_q;
    pe_tag_t     nx_tag;
    pe_beat_t    nx_beat;
    logic        last_line;

    // ceil(num_fv / FV_PER_LINE)
    assign num_lines = (num_fv + fv_count_t'(FV_PER_LINE - 1)) >> LINE_SHIFT;
    assign last_line = (cnt + fv_count_t'(1)) >= num_lines;

    // a read taken this cycle closes the bank to new bursts
    assign bank_free = (state == WRITE_FV) || ((state == IDLE) && !rd_accept);

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            cnt    <= '0;
            pe_out <= '0;
        end else begin
            state  <= nx_state;
            cnt    <= nx_cnt;
            pe_out <= nx_beat;
        end
    end

    always_ff @(posedge clk) begin
        rd_addr <= nx_rd_addr;
        tag_q   <= nx_tag;
    end

    // --------------------
    // next state
    // --------------------
    always_comb begin
        nx_state   = state;
        nx_cnt     = cnt;
        nx_rd_addr = rd_addr;
        nx_tag     = tag_q;
        nx_beat    = '0;
        rd_accept  = 1'b0;
        busy       = 1'b0;
        sram.cen   = 1'b1;
        sram.wen   = 1'b1;
        sram.a     = wr_beat.a;
        sram.d     = wr_beat.data;
        case (state)
            IDLE: begin
                if (wr_beat.sos) begin
                    sram.cen = 1'b0;
                    sram.wen = 1'b0;
                    // single-beat burst is done here
                    if (!wr_beat.eos) begin
                        nx_state = WRITE_FV;
                    end
                end else if (head.valid) begin
                    rd_accept  = 1'b1;
                    sram.cen   = 1'b0;
                    sram.a     = head.addr;
                    nx_rd_addr = head.addr;
                    nx_tag     = head.tag;
                    nx_cnt     = '0;
                    nx_state   = STREAM;
                end
            end
            WRITE_FV: begin
                sram.cen = 1'b0;
                sram.wen = 1'b0;
                if (wr_beat.eos) begin
                    nx_state = IDLE;
                end
            end
            STREAM: begin
                // line cnt is on sram_rdata now
                nx_beat.valid = 1'b1;
                nx_beat.sos   = (cnt == '0);
                nx_beat.eos   = last_line;
                nx_beat.tag   = tag_q;
                nx_beat.data  = sram_rdata;
                if (last_line) begin
                    nx_state = IDLE;
                end else begin
                    busy       = 1'b1;
                    sram.cen   = 1'b0;
                    sram.a     = rd_addr + fv_addr_t'(1);
                    nx_rd_addr = rd_addr + fv_addr_t'(1);
                    nx_cnt     = cnt + fv_count_t'(1);
                end
            end
            default: nx_state = IDLE;
        endcase
    end

    // --------------------
    // checks
    // --------------------

    // beats of one stream are back to back and keep the tag
    a_tag_stable: assert property (
        @(posedge clk) disable iff (reset)
        pe_out.valid && !pe_out.eos |=> pe_out.valid && (pe_out.tag == $past(pe_out.tag))
    );

    // loader holds bursts off while a stream owns the bank
    a_no_sos_in_stream: assert property (
        @(posedge clk) disable iff (reset) (state == STREAM) |-> !wr_beat.sos
    );

endmodule

`default_nettype wire

// File: fv_bank_top.sv
// one feature-vector bank; num_fv is static configuration, PE beats cannot be back-pressured
`timescale 1ns/1ns
`default_nettype none

module fv_bank_top import fv_pkg::*; #(
    parameter int DEPTH       = 256,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  fv_count_t num_fv,
    input  logic      wr_valid,
    input  logic      wr_last,
    input  fv_addr_t  wr_base,
    input  fv_line_t  wr_data,
    output logic      wr_ready,
    input  logic      req_valid,
    input  fv_addr_t  req_addr,
    input  pe_tag_t   req_tag,
    output logic      req_ready,
    output pe_beat_t  pe_out,
    output logic      busy
);

    fv_write_t wr_beat;
    logic      bank_free;
    rd_req_t   head;
    logic      rd_accept;
    sram_req_t sram_req;
    fv_line_t  sram_rdata;

    fv_write_loader loader0 (
        .clk       (clk),
        .reset     (reset),
        .wr_valid  (wr_valid),
        .wr_last   (wr_last),
        .wr_base   (wr_base),
        .wr_data   (wr_data),
        .wr_ready  (wr_ready),
        .bank_free (bank_free),
        .wr_beat   (wr_beat)
    );

    fv_read_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_tag   (req_tag),
        .req_ready (req_ready),
        .head      (head),
        .rd_accept (rd_accept)
    );

    fv_bank_ctrl ctrl0 (
        .clk        (clk),
        .reset      (reset),
        .num_fv     (num_fv),
        .wr_beat    (wr_beat),
        .head       (head),
        .sram_rdata (sram_rdata),
        .rd_accept  (rd_accept),
        .bank_free  (bank_free),
        .sram       (sram_req),
        .pe_out     (pe_out),
        .busy       (busy)
    );

    fv_sram #(.DEPTH(DEPTH)) sram0 (
        .clk   (clk),
        .req   (sram_req),
        .rdata (sram_rdata)
    );

endmodule

`default_nettype wire

// File: tb_fv_bank.sv
// table-driven bank test; reads only touch lines 0..63, which the first two rows fill
`timescale 1ns/1ns
`default_nettype none

module tb_fv_bank import fv_pkg::*; ();

    localparam int DEPTH   = 256;
    localparam int N_FIXED = 10;
    localparam int N_ROWS  = N_FIXED + 12;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_READS, OP_WRITE_IN_STREAM} op_e;

    // one table row; len counts lines for writes and requests for OP_READS
    typedef struct packed {
        op_e        op;
        fv_addr_t   base;
        logic [7:0] len;
        pe_tag_t    tag;
        fv_count_t  nfv;
    } row_t;

    logic      clk;
    logic      reset;
    fv_count_t num_fv;
    logic      wr_valid;
    logic      wr_last;
    fv_addr_t  wr_base;
    fv_line_t  wr_data;
    logic      wr_ready;
    logic      req_valid;
    fv_addr_t  req_addr;
    pe_tag_t   req_tag;
    logic      req_ready;
    pe_beat_t  pe_out;
    logic      busy;

    row_t        rows [N_ROWS];
    fv_line_t    ref_mem [DEPTH];
    pe_beat_t    exp_beats [$];
    int          exp_cycles [$];
    pe_beat_t    exp_beat;
    int          exp_cyc;
    logic [31:0] rng;
    int          cyc = 0;
    int          last_beat_cyc;
    int          first_wr_cyc;
    int          wr_waits;
    bit          saw_full;
    logic        busy_prev;

    fv_bank_top #(.DEPTH(DEPTH), .QUEUE_DEPTH(4)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        assert (act === exp) else begin
            stop_run($sformatf("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic expect_true(input bit ok, input string what);
        assert (ok) else begin
            stop_run($sformatf("ERROR t=%0t: %s", $time, what));
        end
    endtask

    // --------------------
    // stimulus
    // --------------------

    // called right after a rising edge, returns right after the transfer edge
    task automatic send_req(input fv_addr_t a, input pe_tag_t t, input bit timed, input bit hold);
        int       nl;
        int       xfer;
        pe_beat_t b;
        req_valid <= 1'b1;
        req_addr  <= a;
        req_tag   <= t;
        @(negedge clk);
        while (!req_ready) begin
            saw_full = 1'b1;
            @(negedge clk);
        end
        xfer = cyc + 1;
        nl   = (int'(num_fv) + FV_PER_LINE - 1) / FV_PER_LINE;
        for (int k = 0; k < nl; k++) begin
            b       = '0;
            b.valid = 1'b1;
            b.sos   = (k == 0);
            b.eos   = (k == nl - 1);
            b.tag   = t;
            b.data  = ref_mem[a + fv_addr_t'(k)];
            exp_beats.push_back(b);
            // first beat two edges after the request is taken from an idle bank
            exp_cycles.push_back(timed ? xfer + 2 + k : -1);
        end
        last_beat_cyc = xfer + 1 + nl;
        @(posedge clk);
        if (!hold) begin
            req_valid <= 1'b0;
        end
    endtask

    task automatic write_burst(input fv_addr_t base, input int len);
        fv_line_t line;
        wr_waits = 0;
        for (int i = 0; i < len; i++) begin
            rng         = xorshift(rng);
            line[63:32] = rng;
            rng         = xorshift(rng);
            line[31:0]  = rng;
            wr_valid <= 1'b1;
            wr_last  <= (i == len - 1);
            wr_base  <= base;
            wr_data  <= line;
            @(negedge clk);
            while (!wr_ready) begin
                wr_waits++;
                @(negedge clk);
            end
            if (i == 0) begin
                first_wr_cyc = cyc + 1;
            end
            ref_mem[base + fv_addr_t'(i)] = line;
            @(posedge clk);
        end
        wr_valid <= 1'b0;
        wr_last  <= 1'b0;
    endtask

    task automatic drain_stream();
        @(negedge clk);
        while (exp_beats.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic run_row(input row_t r);
        drain_stream();
        num_fv <= r.nfv;
        case (r.op)
            OP_WRITE: write_burst(r.base, int'(r.len));
            OP_READ:  send_req(r.base, r.tag, 1'b1, 1'b0);
            OP_READS: begin
                saw_full = 1'b0;
                for (int i = 0; i < int'(r.len); i++) begin
                    send_req(r.base + fv_addr_t'(4 * i), r.tag + pe_tag_t'(i), 1'b0,
                             i < int'(r.len) - 1);
                end
                // four-line streams are slow enough for four requests to pile up
                if (int'(r.len) >= 6 && int'(r.nfv) > 12) begin
                    expect_true(saw_full, "req_ready stayed high with four requests queued");
                end
            end
            OP_WRITE_IN_STREAM: begin
                send_req(r.base, r.tag, 1'b1, 1'b0);
                write_burst(r.base, int'(r.len));
                expect_true(wr_waits > 0, "wr_ready was high while a read stream held the bank");
                compare_value("first write beat cycle", 64'(last_beat_cyc + 1),
                              64'(first_wr_cyc));
            end
            default: stop_run("ERROR: unknown operation in the stimulus table");
        endcase
    endtask

    task automatic build_table();
        row_t r;
        rows[0] = '{OP_WRITE, 8'd0, 8'd32, 2'd0, 5'd4};
        rows[1] = '{OP_WRITE, 8'd32, 8'd32, 2'd0, 5'd4};
        rows[2] = '{OP_READ, 8'd5, 8'd1, 2'd1, 5'd1};
        rows[3] = '{OP_READ, 8'd10, 8'd1, 2'd2, 5'd4};
        rows[4] = '{OP_READ, 8'd20, 8'd1, 2'd3, 5'd5};
        rows[5] = '{OP_READ, 8'd60, 8'd1, 2'd0, 5'd16};
        rows[6] = '{OP_READS, 8'd0, 8'd6, 2'd0, 5'd16};
        rows[7] = '{OP_WRITE_IN_STREAM, 8'd40, 8'd6, 2'd2, 5'd16};
        rows[8] = '{OP_READ, 8'd40, 8'd1, 2'd1, 5'd16};
        rows[9] = '{OP_READ, 8'd44, 8'd1, 2'd3, 5'd8};
        // random rows stay inside lines 0..63
        for (int i = N_FIXED; i < N_ROWS; i++) begin
            rng    = xorshift(rng);
            r.op   = op_e'(rng[1:0]);
            r.tag  = rng[3:2];
            r.nfv  = {1'b0, rng[7:4]} + 5'd1;
            r.len  = {5'd0, rng[10:8]} + 8'd1;
            r.base = fv_addr_t'(rng[31:24] % 8'd29);
            rows[i] = r;
        end
    endtask

    // --------------------
    // monitor and watchdog
    // --------------------
    always @(negedge clk) begin
        if (!reset && pe_out.valid) begin
            expect_true(exp_beats.size() != 0, "pe_out carried a beat that no read asked for");
            exp_beat = exp_beats.pop_front();
            exp_cyc  = exp_cycles.pop_front();
            compare_value("pe_out.sos", 64'(exp_beat.sos), 64'(pe_out.sos));
            compare_value("pe_out.eos", 64'(exp_beat.eos), 64'(pe_out.eos));
            compare_value("pe_out.tag", 64'(exp_beat.tag), 64'(pe_out.tag));
            compare_value("pe_out.data", exp_beat.data, pe_out.data);
            // busy covers the cycle before every beat of a stream except the last
            compare_value("busy", 64'(!exp_beat.eos), 64'(busy_prev));
            if (exp_cyc >= 0) begin
                compare_value("pe_out beat cycle", 64'(exp_cyc), 64'(cyc));
            end
        end else if (!reset) begin
            compare_value("busy", 64'(0), 64'(busy_prev));
            if (exp_cycles.size() != 0 && exp_cycles[0] >= 0) begin
                expect_true(cyc < exp_cycles[0], "an expected beat did not appear on pe_out");
            end
        end
        busy_prev = busy;
    end

    initial begin
        repeat ((N_ROWS * 40) + 100) @(posedge clk);
        stop_run("ERROR: watchdog expired before the stimulus table finished");
    end

    initial begin
        reset     = 1'b1;
        num_fv    = fv_count_t'(4);
        wr_valid  = 1'b0;
        wr_last   = 1'b0;
        wr_base   = '0;
        wr_data   = '0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_tag   = '0;
        saw_full  = 1'b0;
        rng       = 32'h436;
        build_table();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_value("pe_out.valid", 64'(0), 64'(pe_out.valid));
        compare_value("busy", 64'(0), 64'(busy));
        compare_value("wr_ready", 64'(1), 64'(wr_ready));
        compare_value("req_ready", 64'(1), 64'(req_ready));
        @(posedge clk);
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(rows[r]);
        end
        drain_stream();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
fv_pkg.sv
fv_sram.sv
fv_write_loader.sv
fv_read_queue.sv
fv_bank_ctrl.sv
fv_bank_top.sv
tb_fv_bank.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and judge the result from sim.log
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ns --top-module tb_fv_bank \
    -f src.f -o sim_fv_bank \
    && ./obj_dir/sim_fv_bank > sim.log 2>&1

grep -qs "^Verification passed$" sim.log \
    && echo "PASS" \
    || { echo "FAIL (see sim.log)"; exit 1; }
